// File: design/vgaParams.svh
`ifndef VGA_PARAMS_SVH
`define VGA_PARAMS_SVH

//////////////////////////////
// Raster geometry, 640x480 at 60 Hz
//////////////////////////////
`define H_ACTIVE 640
`define H_FRONT  16
`define H_SYNC   96
`define H_BACK   48
`define H_TOTAL  (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

`define V_ACTIVE 480
`define V_FRONT  10
`define V_SYNC   2
`define V_BACK   33
`define V_TOTAL  (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

`define COORD_W 11

// Player ship sprite
`define SHIP_W 32
`define SHIP_H 16
`define SHIP_Y 440

// Colours packed as blue, green, red
`define COLOR_SPACE 8'hD1
`define COLOR_SHIP  8'h3F
`define COLOR_BLACK 8'h00
`define COLOR_WHITE 8'hFF

`endif

// File: design/displayPkg.sv
`include "vgaParams.svh"

package displayPkg;

	//////////////////////////////
	// Raster types
	//////////////////////////////

	// Pixel position within the full raster, blanking included
	typedef struct packed {
		logic [`COORD_W-1:0] x;
		logic [`COORD_W-1:0] y;
	} pixelCoordT;

	// Everything the timing generator says about one pixel
	typedef struct packed {
		pixelCoordT coord;
		logic       active;
		// Both syncs are active low
		logic       hSync;
		logic       vSync;
		logic       frameStart;
	} rasterT;

	// 8-bit colour, blue in the top bits
	typedef logic [7:0] rgbT;

	// Which screen the sequencer shows
	typedef enum logic {
		SCREEN_PLAY,
		SCREEN_GAMEOVER
	} screenT;

endpackage

// File: design/vgaTiming.sv
`include "vgaParams.svh"

module vgaTiming import displayPkg::*; (
	input  logic   clk,
	input  logic   arstN,
	output rasterT raster
);

	localparam logic [`COORD_W-1:0] H_LAST       = `H_TOTAL - 1;
	localparam logic [`COORD_W-1:0] V_LAST       = `V_TOTAL - 1;
	localparam logic [`COORD_W-1:0] H_VISIBLE    = `H_ACTIVE;
	localparam logic [`COORD_W-1:0] V_VISIBLE    = `V_ACTIVE;
	localparam logic [`COORD_W-1:0] H_SYNC_FIRST = `H_ACTIVE + `H_FRONT;
	localparam logic [`COORD_W-1:0] H_SYNC_LAST  = `H_ACTIVE + `H_FRONT + `H_SYNC - 1;
	localparam logic [`COORD_W-1:0] V_SYNC_FIRST = `V_ACTIVE + `V_FRONT;
	localparam logic [`COORD_W-1:0] V_SYNC_LAST  = `V_ACTIVE + `V_FRONT + `V_SYNC - 1;

	logic [`COORD_W-1:0] hNext;
	logic [`COORD_W-1:0] vNext;
	logic                lineEnd;
	logic                frameEnd;

	//////////////////////////////
	// Next raster position
	//////////////////////////////

	always_comb begin
		lineEnd  = (raster.coord.x == H_LAST);
		frameEnd = (raster.coord.y == V_LAST);
		hNext    = lineEnd ? '0 : raster.coord.x + 1'b1;
		vNext    = raster.coord.y;
		// Vertical count steps once per wrapped line
		if (lineEnd) begin
			vNext = frameEnd ? '0 : raster.coord.y + 1'b1;
		end
	end

	//////////////////////////////
	// Counters and decode
	//////////////////////////////

	// Decode the next position so every field registers with its own coordinate
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			raster.coord.x    <= '0;
			raster.coord.y    <= '0;
			// Reset position is pixel (0,0) of a fresh frame
			raster.active     <= 1'b1;
			raster.hSync      <= 1'b1;
			raster.vSync      <= 1'b1;
			raster.frameStart <= 1'b1;
		end else begin
			raster.coord.x    <= hNext;
			raster.coord.y    <= vNext;
			raster.active     <= (hNext < H_VISIBLE) && (vNext < V_VISIBLE);
			raster.hSync      <= !((hNext >= H_SYNC_FIRST) && (hNext <= H_SYNC_LAST));
			raster.vSync      <= !((vNext >= V_SYNC_FIRST) && (vNext <= V_SYNC_LAST));
			raster.frameStart <= (hNext == '0) && (vNext == '0);
		end
	end

endmodule

// File: design/gameoverScreen.sv
`include "vgaParams.svh"

module gameoverScreen import displayPkg::*; (
	input  logic       clk,
	input  logic       arstN,
	input  pixelCoordT coord,
	output rgbT        rgb
);

	// All five letter cells share one row band
	localparam int CELL_Y_LO = 101;
	localparam int CELL_Y_HI = 149;

	logic inS, inP, inA, inC, inE;
	logic cutS, cutP, cutA, cutC, cutE;
	rgbT  color;

	// Inclusive rectangle test
	function automatic logic boxHit(pixelCoordT p, int xLo, int xHi, int yLo, int yHi);
		return (p.x >= xLo) && (p.x <= xHi) && (p.y >= yLo) && (p.y <= yHi);
	endfunction

	//////////////////////////////
	// Letter cells
	//////////////////////////////

	assign inS = boxHit(coord, 201, 239, CELL_Y_LO, CELL_Y_HI);
	assign inP = boxHit(coord, 251, 289, CELL_Y_LO, CELL_Y_HI);
	assign inA = boxHit(coord, 301, 339, CELL_Y_LO, CELL_Y_HI);
	assign inC = boxHit(coord, 351, 389, CELL_Y_LO, CELL_Y_HI);
	assign inE = boxHit(coord, 401, 439, CELL_Y_LO, CELL_Y_HI);

	//////////////////////////////
	// Cut-outs per letter
	//////////////////////////////

	// S: rounded corners plus the two notches that shape the curve
	assign cutS = boxHit(coord, 201, 209, 101, 104) ||
		boxHit(coord, 231, 239, 101, 104) ||
		boxHit(coord, 211, 229, 111, 119) ||
		boxHit(coord, 230, 239, 115, 124) ||
		boxHit(coord, 201, 209, 126, 134) ||
		boxHit(coord, 210, 229, 131, 139) ||
		boxHit(coord, 201, 209, 146, 149) ||
		boxHit(coord, 231, 239, 146, 149);

	// P: bowl hole and open lower right
	assign cutP = boxHit(coord, 286, 289, 101, 104) ||
		boxHit(coord, 261, 279, 106, 119) ||
		boxHit(coord, 286, 289, 121, 124) ||
		boxHit(coord, 261, 289, 125, 149);

	// A: top corners, counter above the crossbar, gap between the legs
	assign cutA = boxHit(coord, 301, 304, 101, 104) ||
		boxHit(coord, 336, 339, 101, 104) ||
		boxHit(coord, 311, 329, 106, 119) ||
		boxHit(coord, 311, 329, 126, 149);

	assign cutC = boxHit(coord, 351, 359, 101, 104) ||
		boxHit(coord, 381, 389, 101, 104) ||
		boxHit(coord, 361, 379, 111, 139) ||
		boxHit(coord, 380, 389, 116, 134) ||
		boxHit(coord, 351, 359, 146, 149) ||
		boxHit(coord, 381, 389, 146, 149);

	// E: two slots and the short gap on the right of the middle arm
	assign cutE = boxHit(coord, 411, 439, 111, 119) ||
		boxHit(coord, 431, 439, 120, 129) ||
		boxHit(coord, 411, 439, 130, 139);

	always_comb begin
		color = `COLOR_BLACK;
		if (inS) begin
			color = cutS ? `COLOR_BLACK : `COLOR_WHITE;
		end else if (inP) begin
			color = cutP ? `COLOR_BLACK : `COLOR_WHITE;
		end else if (inA) begin
			color = cutA ? `COLOR_BLACK : `COLOR_WHITE;
		end else if (inC) begin
			color = cutC ? `COLOR_BLACK : `COLOR_WHITE;
		end else if (inE) begin
			color = cutE ? `COLOR_BLACK : `COLOR_WHITE;
		end
	end

	// One cycle of latency, matched by the sequencer
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			rgb <= `COLOR_BLACK;
		end else begin
			rgb <= color;
		end
	end

endmodule

// File: design/playfieldScreen.sv
`include "vgaParams.svh"

module playfieldScreen import displayPkg::*; (
	input  logic                clk,
	input  logic                arstN,
	input  pixelCoordT          coord,
	input  logic [`COORD_W-1:0] shipX,
	output rgbT                 rgb
);

	// Ship rows are fixed near the bottom of the screen
	localparam logic [`COORD_W-1:0] SHIP_TOP    = `SHIP_Y;
	localparam logic [`COORD_W-1:0] SHIP_BOTTOM = `SHIP_Y + `SHIP_H - 1;
	// One extra bit so a ship near the right edge cannot wrap
	localparam logic [`COORD_W:0]   SHIP_SPAN   = `SHIP_W - 1;

	logic [`COORD_W:0] shipRight;
	logic              inShipCols;
	logic              inShipRows;
	rgbT               color;

	//////////////////////////////
	// Sprite hit test
	//////////////////////////////

	assign shipRight  = {1'b0, shipX} + SHIP_SPAN;
	assign inShipCols = (coord.x >= shipX) && ({1'b0, coord.x} <= shipRight);
	assign inShipRows = (coord.y >= SHIP_TOP) && (coord.y <= SHIP_BOTTOM);

	// Plain rectangle ship over flat space colour
	always_comb begin
		if (inShipCols && inShipRows) begin
			color = `COLOR_SHIP;
		end else begin
			color = `COLOR_SPACE;
		end
	end

	//////////////////////////////
	// Output register
	//////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			rgb <= `COLOR_BLACK;
		end else begin
			rgb <= color;
		end
	end

endmodule

// File: design/screenSequencer.sv
`include "vgaParams.svh"

module screenSequencer import displayPkg::*; (
	input  logic   clk,
	input  logic   arstN,
	input  rasterT raster,
	input  rgbT    playRgb,
	input  rgbT    overRgb,
	input  logic   gameOver,
	input  logic   restart,
	output logic   hSync,
	output logic   vSync,
	output rgbT    rgb
);

	screenT state;
	screenT stateNext;
	logic   pendOver;
	logic   pendRestart;
	logic   hSyncD;
	logic   vSyncD;
	logic   activeD;
	rgbT    selRgb;

	//////////////////////////////
	// Game state
	//////////////////////////////

	// Pending requests only land on a frame boundary, restart first
	always_comb begin
		stateNext = state;
		if (raster.frameStart) begin
			if (pendRestart) begin
				stateNext = SCREEN_PLAY;
			end else if (pendOver) begin
				stateNext = SCREEN_GAMEOVER;
			end
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state       <= SCREEN_PLAY;
			pendOver    <= 1'b0;
			pendRestart <= 1'b0;
		end else begin
			state <= stateNext;
			if (raster.frameStart) begin
				// Requests seen now wait for the next frame
				pendOver    <= gameOver;
				pendRestart <= restart;
			end else begin
				pendOver    <= pendOver | gameOver;
				pendRestart <= pendRestart | restart;
			end
		end
	end

	//////////////////////////////
	// Renderer select
	//////////////////////////////

	always_comb begin
		unique case (state)
			SCREEN_GAMEOVER: selRgb = overRgb;
			default:         selRgb = playRgb;
		endcase
	end

	//////////////////////////////
	// Alignment and output
	//////////////////////////////

	// First stage matches renderer latency, second is the pin register
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			hSyncD  <= 1'b1;
			vSyncD  <= 1'b1;
			activeD <= 1'b0;
			hSync   <= 1'b1;
			vSync   <= 1'b1;
			rgb     <= `COLOR_BLACK;
		end else begin
			hSyncD  <= raster.hSync;
			vSyncD  <= raster.vSync;
			activeD <= raster.active;
			hSync   <= hSyncD;
			vSync   <= vSyncD;
			rgb     <= activeD ? selRgb : `COLOR_BLACK;
		end
	end

endmodule

// File: design/displayTop.sv
`include "vgaParams.svh"

module displayTop import displayPkg::*; (
	input  logic                clk,
	input  logic                arstN,
	input  logic [`COORD_W-1:0] shipX,
	input  logic                gameOver,
	input  logic                restart,
	output logic                hSync,
	output logic                vSync,
	output rgbT                 rgb
);

	rasterT raster;
	rgbT    playRgb;
	rgbT    overRgb;

	vgaTiming timing (
		.clk    (clk),
		.arstN  (arstN),
		.raster (raster)
	);

	// Both renderers run every pixel, the sequencer picks one
	playfieldScreen playfield (
		.clk   (clk),
		.arstN (arstN),
		.coord (raster.coord),
		.shipX (shipX),
		.rgb   (playRgb)
	);

	gameoverScreen gameover (
		.clk   (clk),
		.arstN (arstN),
		.coord (raster.coord),
		.rgb   (overRgb)
	);

	screenSequencer sequencer (
		.clk      (clk),
		.arstN    (arstN),
		.raster   (raster),
		.playRgb  (playRgb),
		.overRgb  (overRgb),
		.gameOver (gameOver),
		.restart  (restart),
		.hSync    (hSync),
		.vSync    (vSync),
		.rgb      (rgb)
	);

endmodule

// File: verif/displayTb.sv
`include "vgaParams.svh"

module displayTb import displayPkg::*; ();

	localparam int SEED          = 98;
	localparam int LINE_TIMEOUT  = 1000;
	localparam int FRAME_TIMEOUT = 500000;
	localparam int SHIP_START    = 304;

	// Banner sample points and their expected colours
	localparam int SAMPLE_X [6] = '{205, 205, 320, 320, 405, 100};
	localparam int SAMPLE_Y [6] = '{102, 107, 122, 110, 125, 300};
	localparam int SAMPLE_C [6] = '{`COLOR_BLACK, `COLOR_WHITE, `COLOR_WHITE,
		`COLOR_BLACK, `COLOR_WHITE, `COLOR_BLACK};

	logic                clk;
	logic                arstN;
	logic [`COORD_W-1:0] shipX;
	logic                gameOver;
	logic                restart;
	logic                hSync;
	logic                vSync;
	rgbT                 rgb;

	// Position of the pixel now at the pins, rebuilt from the sync edges
	int     trackX;
	int     trackY;
	logic   xLock;
	logic   yLock;
	logic   hPrev;
	logic   vPrev;
	int     hCount;
	int     hLow;
	int     vCount;
	int     vLow;
	logic   hSeen;
	logic   vSeen;
	int     hFallCount;
	int     vFallCount;
	int     sampleHits;
	int     expShipX;
	screenT expScreen;
	logic   trackValid;
	logic   inVisible;

	displayTop uut (
		.clk      (clk),
		.arstN    (arstN),
		.shipX    (shipX),
		.gameOver (gameOver),
		.restart  (restart),
		.hSync    (hSync),
		.vSync    (vSync),
		.rgb      (rgb)
	);

	always #4 clk = ~clk;

	assign trackValid = xLock && yLock;
	assign inVisible  = (trackX < `H_ACTIVE) && (trackY < `V_ACTIVE);

	//////////////////////////////
	// Reporting
	//////////////////////////////

	task automatic reportMismatch(input string testName, input int expected, input int actual);
		$display("Mismatch %s: expected %0d, actual %0d", testName, expected, actual);
		$display("Test failures found");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic reportFailure(input string what);
		$display("%s", what);
		$display("Test failures found");
		$fatal(1, "Stopped at the first error");
	endtask

	//////////////////////////////
	// Reference rules
	//////////////////////////////

	function automatic int playColor(input int x, input int y, input int sx);
		if (x >= sx && x <= sx + `SHIP_W - 1 && y >= `SHIP_Y && y <= `SHIP_Y + `SHIP_H - 1) begin
			return `COLOR_SHIP;
		end
		return `COLOR_SPACE;
	endfunction

	// Five letter cells, 50 columns apart
	function automatic logic inBannerCell(input int x, input int y);
		logic hit;
		hit = 1'b0;
		if (y >= 101 && y <= 149) begin
			for (int k = 0; k < 5; k++) begin
				if (x >= 201 + 50 * k && x <= 239 + 50 * k) begin
					hit = 1'b1;
				end
			end
		end
		return hit;
	endfunction

	// -1 away from the sample points
	function automatic int bannerSample(input int x, input int y);
		int expected;
		expected = -1;
		for (int i = 0; i < 6; i++) begin
			if (x == SAMPLE_X[i] && y == SAMPLE_Y[i]) begin
				expected = SAMPLE_C[i];
			end
		end
		return expected;
	endfunction

	//////////////////////////////
	// Raster tracking and checks
	//////////////////////////////

	// Mid-cycle sampling, the pins only move on the rising edge
	always @(negedge clk) begin
		logic hFall;
		logic hRise;
		logic vFall;
		logic vRise;
		int   expColor;
		if (!arstN) begin
			trackX     = 0;
			trackY     = 0;
			xLock      = 1'b0;
			yLock      = 1'b0;
			hPrev      = 1'b1;
			vPrev      = 1'b1;
			hCount     = 0;
			hLow       = 0;
			vCount     = 0;
			vLow       = 0;
			hSeen      = 1'b0;
			vSeen      = 1'b0;
			hFallCount = 0;
			vFallCount = 0;
			sampleHits = 0;
		end else begin
			hFall  = hPrev && !hSync;
			hRise  = !hPrev && hSync;
			vFall  = vPrev && !vSync;
			vRise  = !vPrev && vSync;
			hCount = hCount + 1;
			vCount = vCount + 1;

			// Sync periods and pulse widths
			if (hFall) begin
				if (hSeen) begin
					assert (hCount == `H_TOTAL) else reportMismatch("hSync period", `H_TOTAL, hCount);
				end
				hSeen  = 1'b1;
				hCount = 0;
				hLow   = 0;
			end
			if (!hSync) begin
				hLow = hLow + 1;
			end
			if (hRise && hSeen) begin
				assert (hLow == `H_SYNC) else reportMismatch("hSync width", `H_SYNC, hLow);
			end
			if (vFall) begin
				if (vSeen) begin
					assert (vCount == `H_TOTAL * `V_TOTAL)
						else reportMismatch("vSync period", `H_TOTAL * `V_TOTAL, vCount);
				end
				vSeen  = 1'b1;
				vCount = 0;
				vLow   = 0;
			end
			if (!vSync) begin
				vLow = vLow + 1;
			end
			if (vRise && vSeen) begin
				assert (vLow == `H_TOTAL * `V_SYNC)
					else reportMismatch("vSync width", `H_TOTAL * `V_SYNC, vLow);
			end

			// hSync falls on column 656, pixel 0 follows 144 cycles later
			if (hFall) begin
				trackX     = `H_ACTIVE + `H_FRONT;
				xLock      = 1'b1;
				hFallCount = hFallCount + 1;
			end else if (xLock) begin
				if (trackX == `H_TOTAL - 1) begin
					trackX = 0;
					if (yLock) begin
						trackY = (trackY == `V_TOTAL - 1) ? 0 : trackY + 1;
					end
				end else begin
					trackX = trackX + 1;
				end
			end
			if (vFall) begin
				if (xLock) begin
					assert (trackX == 0) else reportMismatch("vSync edge column", 0, trackX);
				end
				trackY     = `V_ACTIVE + `V_FRONT;
				yLock      = 1'b1;
				vFallCount = vFallCount + 1;
			end

			// Visible pixels against the screen the frame should show
			if (xLock && yLock && trackX < `H_ACTIVE && trackY < `V_ACTIVE) begin
				if (expScreen == SCREEN_PLAY) begin
					expColor = playColor(trackX, trackY, expShipX);
					assert (rgb == expColor)
						else reportMismatch($sformatf("playfield (%0d,%0d)", trackX, trackY),
							expColor, rgb);
				end else begin
					expColor = bannerSample(trackX, trackY);
					if (expColor >= 0) begin
						sampleHits = sampleHits + 1;
						assert (rgb == expColor)
							else reportMismatch($sformatf("banner (%0d,%0d)", trackX, trackY),
								expColor, rgb);
					end else if (!inBannerCell(trackX, trackY)) begin
						assert (rgb == `COLOR_BLACK)
							else reportMismatch($sformatf("banner background (%0d,%0d)",
								trackX, trackY), `COLOR_BLACK, rgb);
					end else begin
						assert (rgb == `COLOR_WHITE || rgb == `COLOR_BLACK)
							else reportMismatch("banner letter colour", `COLOR_WHITE, rgb);
					end
				end
			end
			hPrev = hSync;
			vPrev = vSync;
		end
	end

	// Nothing but black outside 640x480
	blankCheck: assert property (@(posedge clk) disable iff (!arstN)
		(trackValid && !inVisible) |-> (rgb == `COLOR_BLACK))
		else reportMismatch("blanking", `COLOR_BLACK, $sampled(rgb));

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	task automatic waitFrame();
		int start;
		int cycles;
		start  = vFallCount;
		cycles = 0;
		while (vFallCount == start) begin
			@(posedge clk);
			cycles = cycles + 1;
			if (cycles > FRAME_TIMEOUT) begin
				reportFailure("Timeout waiting for a vSync falling edge");
			end
		end
	endtask

	task automatic waitLineStart();
		int start;
		int cycles;
		start  = hFallCount;
		cycles = 0;
		while (hFallCount == start) begin
			@(posedge clk);
			cycles = cycles + 1;
			if (cycles > LINE_TIMEOUT) begin
				reportFailure("Timeout waiting for an hSync falling edge");
			end
		end
	endtask

	task automatic waitLine(input int line);
		int lines;
		lines = 0;
		waitLineStart();
		while (trackY != line) begin
			waitLineStart();
			lines = lines + 1;
			if (lines > `V_TOTAL) begin
				reportFailure($sformatf("Line %0d never reached", line));
			end
		end
	endtask

	task automatic sendPulse(input logic over, input logic back);
		@(posedge clk);
		gameOver <= over;
		restart  <= back;
		@(posedge clk);
		gameOver <= 1'b0;
		restart  <= 1'b0;
	endtask

	initial begin
		int pick;
		clk       = 1'b0;
		arstN     = 1'b0;
		shipX     = SHIP_START;
		gameOver  = 1'b0;
		restart   = 1'b0;
		expShipX  = SHIP_START;
		expScreen = SCREEN_PLAY;
		void'($urandom(SEED));
		repeat (8) @(posedge clk);
		arstN <= 1'b1;

		// Lock onto the raster, then one full playfield frame
		waitFrame();
		waitFrame();

		// New ship columns land during vertical blanking
		for (int i = 0; i < 2; i++) begin
			pick = $urandom % 601;
			shipX    <= `COORD_W'(pick);
			expShipX = pick;
			waitFrame();
		end

		// Game over mid-frame, banner from the next frame on
		waitLine(240);
		sendPulse(1'b1, 1'b0);
		waitFrame();
		expScreen = SCREEN_GAMEOVER;
		waitFrame();

		waitLine(200);
		sendPulse(1'b0, 1'b1);
		waitFrame();
		expScreen = SCREEN_PLAY;
		waitFrame();

		// Both requests in one frame, playfield stays
		waitLine(100);
		sendPulse(1'b1, 1'b0);
		waitLine(300);
		sendPulse(1'b0, 1'b1);
		waitFrame();
		waitFrame();

		// Two full banner frames, each passing every sample point
		assert (sampleHits == 12) begin
			$display("All tests passed!");
			$finish;
		end else begin
			reportMismatch("banner samples reached", 12, sampleHits);
		end
	end

endmodule

// File: tb.f
+incdir+design
design/displayPkg.sv
design/vgaTiming.sv
design/gameoverScreen.sv
design/playfieldScreen.sv
design/screenSequencer.sv
design/displayTop.sv
verif/displayTb.sv
